// File: Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module tb_rv_core -f list.f

run: compile
	./obj_dir/Vtb_rv_core | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: hw/rv_alu.sv
`timescale 1ns/100ps

module rv_alu (
  rv_ctrl_if.dp       ctl,
  input  logic [31:0] pc,
  input  logic [31:0] rs1_data,
  input  logic [31:0] rs2_data,
  input  logic [2:0]  funct3,
  output logic [31:0] result,
  output logic        branch_taken
);

  logic [31:0] op_a, op_b;
  logic [4:0]  shamt;

  assign op_a  = ctl.alu_src_pc ? pc : rs1_data;
  assign op_b  = ctl.alu_src_imm ? ctl.imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (ctl.alu_op)
      rv_pkg::ALU_ADD:    result = op_a + op_b;
      rv_pkg::ALU_SUB:    result = op_a - op_b;
      rv_pkg::ALU_SLL:    result = op_a << shamt;
      rv_pkg::ALU_SLT:    result = {31'd0, $signed(op_a) < $signed(op_b)};
      rv_pkg::ALU_SLTU:   result = {31'd0, op_a < op_b};
      rv_pkg::ALU_XOR:    result = op_a ^ op_b;
      rv_pkg::ALU_SRL:    result = op_a >> shamt;
      rv_pkg::ALU_SRA:    result = $unsigned($signed(op_a) >>> shamt);
      rv_pkg::ALU_OR:     result = op_a | op_b;
      rv_pkg::ALU_AND:    result = op_a & op_b;
      rv_pkg::ALU_PASS_B: result = op_b;
      default:            result = op_a + op_b;
    endcase
  end

  // Branch conditions always compare the two registers
  always_comb begin
    case (funct3)
      3'b000:  branch_taken = rs1_data == rs2_data;
      3'b001:  branch_taken = rs1_data != rs2_data;
      3'b100:  branch_taken = $signed(rs1_data) < $signed(rs2_data);
      3'b101:  branch_taken = $signed(rs1_data) >= $signed(rs2_data);
      3'b110:  branch_taken = rs1_data < rs2_data;
      3'b111:  branch_taken = rs1_data >= rs2_data;
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

// File: hw/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define RV_RESET_PC 32'h8000_0000

// Machine CSR addresses
`define RV_CSR_MSTATUS 12'h300
`define RV_CSR_MTVEC 12'h305
`define RV_CSR_MEPC 12'h341
`define RV_CSR_MCAUSE 12'h342

`define RV_CAUSE_ECALL 32'd11 // Environment call from M-mode

`endif

// File: hw/rv_control.sv
`timescale 1ns/100ps
`include "rv_consts.svh"

module rv_control (
  input  logic           clk,
  input  logic           rst,
  input  logic [31:0]    instr,
  input  logic           branch_taken,
  input  logic [31:0]    trap_pc,
  input  logic [31:0]    alu_result,
  output logic [31:0]    pc,
  output logic           halt,
  rv_ctrl_if.ctrl        ctl
);

  rv_pkg::opcode_e opcode;
  logic [2:0]  funct3;
  logic        funct7_alt;
  logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [31:0] imm_sel;
  logic [31:0] pc_next;
  logic        is_jal, is_jalr, is_branch, is_trap, is_ebreak;

  assign opcode     = rv_pkg::opcode_e'(instr[6:0]);
  assign funct3     = instr[14:12];
  assign funct7_alt = instr[30];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'd0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  function automatic rv_pkg::alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
    rv_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      3'b001:  op = rv_pkg::ALU_SLL;
      3'b010:  op = rv_pkg::ALU_SLT;
      3'b011:  op = rv_pkg::ALU_SLTU;
      3'b100:  op = rv_pkg::ALU_XOR;
      3'b101:  op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  op = rv_pkg::ALU_OR;
      default: op = rv_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    ctl.alu_op      = rv_pkg::ALU_ADD;
    ctl.alu_src_imm = 1'b0;
    ctl.alu_src_pc  = 1'b0;
    ctl.wb_sel      = rv_pkg::WB_ALU;
    ctl.rf_wen      = 1'b0;
    ctl.mem_re      = 1'b0;
    ctl.mem_we      = 1'b0;
    ctl.csr_op      = rv_pkg::CSR_NONE;
    imm_sel         = imm_i;
    is_jal          = 1'b0;
    is_jalr         = 1'b0;
    is_branch       = 1'b0;
    is_ebreak       = 1'b0;
    case (opcode)
      rv_pkg::OPC_LUI: begin
        ctl.alu_op      = rv_pkg::ALU_PASS_B;
        ctl.alu_src_imm = 1'b1;
        ctl.rf_wen      = 1'b1;
        imm_sel         = imm_u;
      end
      rv_pkg::OPC_AUIPC: begin
        ctl.alu_src_imm = 1'b1;
        ctl.alu_src_pc  = 1'b1;
        ctl.rf_wen      = 1'b1;
        imm_sel         = imm_u;
      end
      rv_pkg::OPC_JAL: begin
        ctl.wb_sel = rv_pkg::WB_PC4;
        ctl.rf_wen = 1'b1;
        imm_sel    = imm_j;
        is_jal     = 1'b1;
      end
      rv_pkg::OPC_JALR: begin
        ctl.alu_src_imm = 1'b1; // Target is rs1 + imm
        ctl.wb_sel      = rv_pkg::WB_PC4;
        ctl.rf_wen      = 1'b1;
        is_jalr         = 1'b1;
      end
      rv_pkg::OPC_BRANCH: begin
        imm_sel   = imm_b;
        is_branch = 1'b1;
      end
      rv_pkg::OPC_LOAD: begin
        ctl.alu_src_imm = 1'b1;
        ctl.wb_sel      = rv_pkg::WB_MEM;
        ctl.rf_wen      = 1'b1;
        ctl.mem_re      = 1'b1;
      end
      rv_pkg::OPC_STORE: begin
        ctl.alu_src_imm = 1'b1;
        ctl.mem_we      = 1'b1;
        imm_sel         = imm_s;
      end
      rv_pkg::OPC_OP_IMM: begin
        ctl.alu_op      = alu_from_funct(funct3, funct3 == 3'b101 && funct7_alt);
        ctl.alu_src_imm = 1'b1;
        ctl.rf_wen      = 1'b1;
      end
      rv_pkg::OPC_OP: begin
        ctl.alu_op = alu_from_funct(funct3, funct7_alt);
        ctl.rf_wen = 1'b1;
      end
      rv_pkg::OPC_SYSTEM: begin
        if (funct3 == 3'b001 || funct3 == 3'b010) begin
          ctl.csr_op = (funct3 == 3'b001) ? rv_pkg::CSR_RW : rv_pkg::CSR_RS;
          ctl.wb_sel = rv_pkg::WB_CSR;
          ctl.rf_wen = 1'b1;
        end else if (funct3 == 3'b000) begin
          case (instr[31:20])
            12'h000: ctl.csr_op = rv_pkg::CSR_ECALL;
            12'h001: is_ebreak  = 1'b1;
            12'h302: ctl.csr_op = rv_pkg::CSR_MRET;
            default: ;
          endcase
        end
      end
      default: ;
    endcase
  end

  always_comb begin
    case (funct3[1:0])
      2'b00:   ctl.mem_size = rv_pkg::MEM_BYTE;
      2'b01:   ctl.mem_size = rv_pkg::MEM_HALF;
      default: ctl.mem_size = rv_pkg::MEM_WORD;
    endcase
  end

  assign ctl.mem_unsigned = funct3[2];
  assign ctl.imm          = imm_sel;
  assign ctl.csr_addr     = instr[31:20];

  assign is_trap = (ctl.csr_op == rv_pkg::CSR_ECALL) || (ctl.csr_op == rv_pkg::CSR_MRET);

  always_comb begin
    if (halt || is_ebreak) begin
      pc_next = pc; // Park on the ebreak
    end else if (is_trap) begin
      pc_next = trap_pc;
    end else if (is_jalr) begin
      pc_next = {alu_result[31:1], 1'b0};
    end else if (is_jal || (is_branch && branch_taken)) begin
      pc_next = pc + imm_sel;
    end else begin
      pc_next = pc + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc   <= `RV_RESET_PC;
      halt <= 1'b0;
    end else begin
      pc <= pc_next;
      if (is_ebreak) begin
        halt <= 1'b1;
      end
    end
  end

  a_halt_sticky: assert property (@(posedge clk) disable iff (rst) halt |=> halt);

endmodule

// File: hw/rv_core.sv
`timescale 1ns/100ps

module rv_core (
  input  logic        clk,
  input  logic        rst,
  output logic [31:0] imem_addr,
  input  logic [31:0] imem_data,
  output logic [31:0] dmem_addr,
  output logic        dmem_re,
  input  logic [31:0] dmem_rdata,
  output logic        dmem_we,
  output logic [3:0]  dmem_wstrb,
  output logic [31:0] dmem_wdata,
  output logic        halt,
  output logic [31:0] a0
);

  rv_ctrl_if ctl ();

  logic [31:0] pc;
  logic [31:0] rs1_data, rs2_data;
  logic [31:0] alu_result;
  logic        branch_taken;
  logic [31:0] csr_rdata, trap_pc;
  logic [31:0] load_data;
  logic [31:0] wb_data;
  logic        freeze;

  assign imem_addr = pc;
  assign freeze    = halt || rst; // No side effects while held in reset

  rv_control i_control (
    .clk          (clk),
    .rst          (rst),
    .instr        (imem_data),
    .branch_taken (branch_taken),
    .trap_pc      (trap_pc),
    .alu_result   (alu_result),
    .pc           (pc),
    .halt         (halt),
    .ctl          (ctl.ctrl)
  );

  rv_regfile i_regfile (
    .clk    (clk),
    .raddr1 (imem_data[19:15]),
    .raddr2 (imem_data[24:20]),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data),
    .waddr  (imem_data[11:7]),
    .wdata  (wb_data),
    .wen    (ctl.rf_wen && !freeze),
    .a0     (a0)
  );

  rv_alu i_alu (
    .ctl          (ctl.dp),
    .pc           (pc),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .funct3       (imem_data[14:12]),
    .result       (alu_result),
    .branch_taken (branch_taken)
  );

  rv_csr i_csr (
    .clk       (clk),
    .rst       (rst),
    .halt      (freeze),
    .pc        (pc),
    .ctl       (ctl.dp),
    .rs1_data  (rs1_data),
    .csr_rdata (csr_rdata),
    .trap_pc   (trap_pc)
  );

  rv_lsu i_lsu (
    .ctl        (ctl.dp),
    .halt       (freeze),
    .addr       (alu_result),
    .rs2_data   (rs2_data),
    .dmem_rdata (dmem_rdata),
    .dmem_addr  (dmem_addr),
    .dmem_re    (dmem_re),
    .dmem_we    (dmem_we),
    .dmem_wstrb (dmem_wstrb),
    .dmem_wdata (dmem_wdata),
    .load_data  (load_data)
  );

  always_comb begin
    case (ctl.wb_sel)
      rv_pkg::WB_MEM: wb_data = load_data;
      rv_pkg::WB_PC4: wb_data = pc + 32'd4; // Link address
      rv_pkg::WB_CSR: wb_data = csr_rdata;
      default:        wb_data = alu_result;
    endcase
  end

endmodule

// File: hw/rv_csr.sv
`timescale 1ns/100ps
`include "rv_consts.svh"

module rv_csr (
  input  logic        clk,
  input  logic        rst,
  input  logic        halt,
  input  logic [31:0] pc,
  rv_ctrl_if.dp       ctl,
  input  logic [31:0] rs1_data,
  output logic [31:0] csr_rdata,
  output logic [31:0] trap_pc
);

  logic [31:0] mstatus, mtvec, mepc, mcause;
  logic [31:0] csr_wdata;

  always_comb begin
    case (ctl.csr_addr)
      `RV_CSR_MSTATUS: csr_rdata = mstatus;
      `RV_CSR_MTVEC:   csr_rdata = mtvec;
      `RV_CSR_MEPC:    csr_rdata = mepc;
      `RV_CSR_MCAUSE:  csr_rdata = mcause;
      default:         csr_rdata = 32'd0;
    endcase
  end

  assign csr_wdata = (ctl.csr_op == rv_pkg::CSR_RS) ? (csr_rdata | rs1_data) : rs1_data;
  assign trap_pc   = (ctl.csr_op == rv_pkg::CSR_MRET) ? mepc : mtvec;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= 32'd0;
      mtvec   <= 32'd0;
      mepc    <= 32'd0;
      mcause  <= 32'd0;
    end else if (!halt) begin
      case (ctl.csr_op)
        rv_pkg::CSR_RW, rv_pkg::CSR_RS: begin
          case (ctl.csr_addr)
            `RV_CSR_MSTATUS: mstatus <= csr_wdata;
            `RV_CSR_MTVEC:   mtvec   <= csr_wdata;
            `RV_CSR_MEPC:    mepc    <= csr_wdata;
            `RV_CSR_MCAUSE:  mcause  <= csr_wdata;
            default: ; // Unknown CSR ignores the write
          endcase
        end
        rv_pkg::CSR_ECALL: begin
          mepc          <= pc;
          mcause        <= `RV_CAUSE_ECALL;
          mstatus[7]    <= mstatus[3]; // MPIE gets MIE
          mstatus[3]    <= 1'b0;
          mstatus[12:11] <= 2'b11;     // MPP is M-mode
        end
        rv_pkg::CSR_MRET: begin
          mstatus[3] <= mstatus[7];
          mstatus[7] <= 1'b1;
        end
        default: ;
      endcase
    end
  end

endmodule

// File: hw/rv_ctrl_if.sv
`timescale 1ns/100ps

interface rv_ctrl_if;
  rv_pkg::alu_op_e   alu_op;
  logic              alu_src_imm; // Operand b is the immediate
  logic              alu_src_pc;  // Operand a is the PC
  logic [31:0]       imm;
  rv_pkg::wb_sel_e   wb_sel;
  logic              rf_wen;
  logic              mem_re;
  logic              mem_we;
  rv_pkg::mem_size_e mem_size;
  logic              mem_unsigned;
  rv_pkg::csr_op_e   csr_op;
  logic [11:0]       csr_addr;

  modport ctrl (
    output alu_op, alu_src_imm, alu_src_pc, imm, wb_sel, rf_wen,
    output mem_re, mem_we, mem_size, mem_unsigned, csr_op, csr_addr
  );

  modport dp (
    input alu_op, alu_src_imm, alu_src_pc, imm, wb_sel, rf_wen,
    input mem_re, mem_we, mem_size, mem_unsigned, csr_op, csr_addr
  );
endinterface

// File: hw/rv_lsu.sv
`timescale 1ns/100ps

module rv_lsu (
  rv_ctrl_if.dp       ctl,
  input  logic        halt,
  input  logic [31:0] addr,
  input  logic [31:0] rs2_data,
  input  logic [31:0] dmem_rdata,
  output logic [31:0] dmem_addr,
  output logic        dmem_re,
  output logic        dmem_we,
  output logic [3:0]  dmem_wstrb,
  output logic [31:0] dmem_wdata,
  output logic [31:0] load_data
);

  logic [4:0]  lane_shift;
  logic [31:0] rdata_shifted;

  assign lane_shift = {addr[1:0], 3'b000};
  assign dmem_addr  = {addr[31:2], 2'b00};
  assign dmem_re    = ctl.mem_re && !halt;
  assign dmem_we    = ctl.mem_we && !halt;
  assign dmem_wdata = rs2_data << lane_shift;

  always_comb begin
    case (ctl.mem_size)
      rv_pkg::MEM_BYTE: dmem_wstrb = 4'b0001 << addr[1:0];
      rv_pkg::MEM_HALF: dmem_wstrb = 4'b0011 << addr[1:0];
      default:          dmem_wstrb = 4'b1111;
    endcase
  end

  assign rdata_shifted = dmem_rdata >> lane_shift; // Addressed lane to bit 0

  always_comb begin
    case (ctl.mem_size)
      rv_pkg::MEM_BYTE:
        load_data = {{24{rdata_shifted[7] & !ctl.mem_unsigned}}, rdata_shifted[7:0]};
      rv_pkg::MEM_HALF:
        load_data = {{16{rdata_shifted[15] & !ctl.mem_unsigned}}, rdata_shifted[15:0]};
      default:
        load_data = dmem_rdata;
    endcase
  end

  always_comb begin
    a_no_rd_wr: assert final (!(dmem_we && dmem_re))
      else $error("dmem read and write strobes both active");
  end

endmodule

// File: hw/rv_pkg.sv
package rv_pkg;

  // RV32I major opcodes
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B // For lui
  } alu_op_e;

  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4, WB_CSR} wb_sel_e;

  typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_e;

  typedef enum logic [2:0] {
    CSR_NONE,
    CSR_RW,
    CSR_RS,
    CSR_ECALL,
    CSR_MRET
  } csr_op_e;

endpackage

// File: hw/rv_regfile.sv
`timescale 1ns/100ps

module rv_regfile (
  input  logic        clk,
  input  logic [4:0]  raddr1,
  input  logic [4:0]  raddr2,
  output logic [31:0] rdata1,
  output logic [31:0] rdata2,
  input  logic [4:0]  waddr,
  input  logic [31:0] wdata,
  input  logic        wen,
  output logic [31:0] a0
);

  logic [31:0] regs [31:1]; // x0 has no storage

  always_ff @(posedge clk) begin
    if (wen && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
  assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];
  assign a0     = regs[10];

  // A write aimed at x0 must not show up on a later read
  a_x0_zero: assert property (@(posedge clk)
    (wen && waddr == 5'd0) |=> ((raddr1 != 5'd0 || rdata1 == 32'd0) &&
                                (raddr2 != 5'd0 || rdata2 == 32'd0)));

endmodule

// File: list.f
+incdir+hw
hw/rv_pkg.sv
hw/rv_ctrl_if.sv
hw/rv_control.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_csr.sv
hw/rv_lsu.sv
hw/rv_core.sv
sim/tb_rv_core.sv

// File: sim/tb_rv_core.sv
`timescale 1ns/100ps
`include "rv_consts.svh"

module tb_rv_core;

  localparam logic [31:0] DATA_BASE = 32'h8000_1000;
  localparam logic [31:0] EBREAK    = 32'h0010_0073;

  logic        clk, rst;
  logic [31:0] imem_addr, imem_data, dmem_addr, dmem_rdata, dmem_wdata, a0;
  logic        dmem_re, dmem_we, halt;
  logic [3:0]  dmem_wstrb;
  logic [31:0] imem [0:255];
  logic [7:0]  dmem [0:1023];
  logic [31:0] ioff, doff;
  logic [31:0] seed = 32'h5cc857e4;
  int          errors = 0;
  int          timeouts = 0;
  int          pc_idx = 0;

  rv_core i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [7:0] fill_byte(input logic [31:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24];
  endfunction

  // Memories answer in the same cycle
  assign ioff       = imem_addr - `RV_RESET_PC;
  assign doff       = dmem_addr - DATA_BASE;
  assign imem_data  = (ioff < 32'd1024) ? imem[ioff[9:2]] : EBREAK;
  assign dmem_rdata = (doff >= 32'd1024) ? 32'd0 :
      {dmem[doff[9:0] + 10'd3], dmem[doff[9:0] + 10'd2], dmem[doff[9:0] + 10'd1], dmem[doff[9:0]]};

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 1024; i++) begin
        dmem[i] <= fill_byte(DATA_BASE + i); // Refill while in reset
      end
    end else if (dmem_we && doff < 32'd1024) begin
      for (int i = 0; i < 4; i++) begin
        if (dmem_wstrb[i]) begin
          dmem[doff[9:0] + i] <= dmem_wdata[8*i +: 8];
        end
      end
    end
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] i_type(input logic [31:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [31:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] b_type(input logic [31:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
      input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type(input logic [31:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  function automatic logic [31:0] csr_instr(input logic [11:0] csr, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd);
    return {csr, rs1, f3, rd, 7'h73};
  endfunction

  // Expected values straight from the ISA definitions
  function automatic logic [31:0] rv32_op(input logic [2:0] f3, input logic alt,
      input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'd0, $signed(a) < $signed(b)};
      3'd3:    return {31'd0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
      input logic [31:0] b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [31:0] mem_word(input int off);
    return {dmem[off + 3], dmem[off + 2], dmem[off + 1], dmem[off]};
  endfunction

  function automatic logic [31:0] here_addr();
    return `RV_RESET_PC + 4 * pc_idx;
  endfunction

  task automatic emit(input logic [31:0] instr);
    imem[pc_idx] = instr;
    pc_idx++;
  endtask

  task automatic start_program();
    foreach (imem[i]) imem[i] = EBREAK;
    pc_idx = 0;
    emit(u_type(DATA_BASE[31:12], 5, 'h37)); // x5 points at data
  endtask

  task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = v + 32'h800; // Compensate addi sign extension
    emit(u_type(hi[31:12], rd, 'h37));
    emit(i_type(v, rd, 0, rd, 'h13));
  endtask

  task automatic expect_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp) else begin
      errors++;
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic expect_true(input logic ok, input string what);
    assert (ok === 1'b1) else begin
      errors++;
      $display("At %0t: %s", $time, what);
    end
  endtask

  // Reset, check the first cycle, then wait for ebreak
  task automatic run_program(input string name);
    int cycles;
    @(posedge clk);
    rst <= 1'b1;
    repeat (10) begin
      @(negedge clk);
      expect_true(!dmem_we && !dmem_re, "memory strobe active during reset");
    end
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    expect_true(!halt && !dmem_we && !dmem_re, "halt or memory strobe high after reset");
    expect_word(imem_addr, `RV_RESET_PC, "first fetch address");
    cycles = 0;
    while (!halt && cycles < 5000) begin
      @(negedge clk);
      cycles++;
    end
    if (!halt) begin
      timeouts++;
      $display("Timeout: %s program did not halt within %0d cycles", name, cycles);
    end
  endtask

  task automatic test_alu();
    logic [31:0] a, b, imm, pc_a;
    logic [31:0] exp [$];
    logic [2:0]  f3;
    logic        alt;
    start_program();
    a = next_rand();
    b = next_rand();
    load_const(1, a);
    load_const(2, b);
    for (int k = 0; k < 10; k++) begin
      f3  = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);
      alt = (k >= 8); // sub and sra
      emit(r_type({1'b0, alt, 5'd0}, 2, 1, f3, 3));
      emit(s_type(4 * exp.size(), 3, 5, 2));
      exp.push_back(rv32_op(f3, alt, a, b));
      if (k != 8) begin
        imm = next_rand();
        if (f3 == 3'd1 || f3 == 3'd5) imm = {21'd0, alt, 5'd0, imm[4:0]};
        else imm = {{20{imm[11]}}, imm[11:0]};
        emit(i_type(imm, 1, f3, 4, 'h13));
        emit(s_type(4 * exp.size(), 4, 5, 2));
        exp.push_back(rv32_op(f3, alt, a, imm));
      end
    end
    imm  = next_rand();
    pc_a = here_addr();
    emit(u_type(imm[31:12], 6, 'h17));
    emit(s_type(4 * exp.size(), 6, 5, 2));
    exp.push_back(pc_a + {imm[31:12], 12'd0});
    run_program("ALU");
    foreach (exp[i]) expect_word(mem_word(4 * i), exp[i], $sformatf("ALU result %0d", i));
  endtask

  task automatic test_load_store();
    logic [31:0] v [4];
    logic [7:0]  eb [8];
    logic [31:0] exp [$];
    logic [31:0] e;
    logic [15:0] h;
    logic [2:0]  f3;
    int          off;
    start_program();
    for (int i = 0; i < 4; i++) begin
      v[i] = next_rand();
      v[i] = (i % 2 == 0) ? v[i] | 32'h8080_8080 : v[i] & 32'h7f7f_7f7f; // Both signs
      eb[i] = v[i][7:0];
      load_const(5'(6 + i), v[i]);
      emit(s_type(32'h40 + i, 5'(6 + i), 5, 0));
    end
    emit(s_type('h44, 6, 5, 1));
    emit(s_type('h46, 7, 5, 1));
    {eb[5], eb[4]} = v[0][15:0];
    {eb[7], eb[6]} = v[1][15:0];
    for (int k = 0; k < 14; k++) begin
      if (k < 8) begin
        f3  = (k < 4) ? 3'd0 : 3'd4;
        off = k % 4;
      end else if (k < 12) begin
        f3  = (k < 10) ? 3'd1 : 3'd5;
        off = 4 + 2 * (k % 2);
      end else begin
        f3  = 3'd2;
        off = 4 * (k - 12);
      end
      h = {eb[off + 1], eb[off]};
      case (f3)
        3'd0:    e = {{24{eb[off][7]}}, eb[off]};
        3'd4:    e = {24'd0, eb[off]};
        3'd1:    e = {{16{h[15]}}, h};
        3'd5:    e = {16'd0, h};
        default: e = {eb[off + 3], eb[off + 2], h};
      endcase
      exp.push_back(e);
      emit(i_type(32'h40 + off, 5, f3, 10, 'h03));
      emit(s_type(32'h80 + 4 * k, 10, 5, 2));
    end
    run_program("load/store");
    expect_word(mem_word('h40), {eb[3], eb[2], eb[1], eb[0]}, "byte stores");
    expect_word(mem_word('h44), {eb[7], eb[6], eb[5], eb[4]}, "half stores");
    expect_word(mem_word('h48), {fill_byte(DATA_BASE + 'h4b), fill_byte(DATA_BASE + 'h4a),
        fill_byte(DATA_BASE + 'h49), fill_byte(DATA_BASE + 'h48)}, "word after stores");
    foreach (exp[i]) expect_word(mem_word('h80 + 4 * i), exp[i], $sformatf("load %0d", i));
  endtask

  task automatic test_control_flow();
    logic [31:0] rv [4];
    logic [31:0] exp [$];
    logic [31:0] link_jal, link_jalr;
    logic [4:0]  r1, r2;
    logic [2:0]  f3;
    start_program();
    rv = '{32'd0, 32'hffff_fffb, 32'd3, 32'hffff_fffb}; // x3 copies x1
    for (int r = 1; r < 4; r++) load_const(5'(r), rv[r]);
    for (int t = 0; t < 6; t++) begin
      for (int p = 0; p < 3; p++) begin
        f3 = (t < 2) ? 3'(t) : 3'(t + 2);
        r1 = (p == 1) ? 5'd2 : 5'd1;
        r2 = (p == 0) ? 5'd2 : ((p == 1) ? 5'd1 : 5'd3);
        emit(b_type(12, r2, r1, f3));
        emit(i_type('h100 + exp.size(), 0, 0, 20, 'h13)); // Fall-through marker
        emit(j_type(8, 0));
        emit(i_type('h200 + exp.size(), 0, 0, 20, 'h13)); // Taken marker
        emit(s_type(4 * exp.size(), 20, 5, 2));
        exp.push_back((branch_ref(f3, rv[r1], rv[r2]) ? 'h200 : 'h100) + exp.size());
      end
    end
    emit(i_type('h11, 0, 0, 22, 'h13));
    link_jal = here_addr() + 4;
    emit(j_type(8, 21));
    emit(i_type('h55, 0, 0, 22, 'h13));
    link_jalr = here_addr() + 8;
    emit(u_type(0, 23, 'h17));
    emit(i_type(13, 23, 0, 24, 'h67)); // Odd offset, bit 0 dropped
    emit(i_type('h66, 0, 0, 22, 'h13));
    emit(s_type('h100, 21, 5, 2));
    emit(s_type('h104, 24, 5, 2));
    emit(s_type('h108, 22, 5, 2));
    run_program("control flow");
    foreach (exp[i]) expect_word(mem_word(4 * i), exp[i], $sformatf("branch marker %0d", i));
    expect_word(mem_word('h100), link_jal, "jal link");
    expect_word(mem_word('h104), link_jalr, "jalr link");
    expect_word(mem_word('h108), 32'h11, "marker behind jumps");
  endtask

  task automatic test_csr_trap();
    logic [31:0] handler, ecall_pc, ms_trap, ms_ret;
    start_program();
    handler = `RV_RESET_PC + 32'h100;
    emit(u_type(0, 1, 'h17));
    emit(i_type(handler - here_addr() + 4, 1, 0, 1, 'h13));
    emit(csr_instr(`RV_CSR_MTVEC, 1, 1, 0));
    emit(i_type(8, 0, 0, 11, 'h13));
    emit(csr_instr(`RV_CSR_MSTATUS, 11, 2, 0)); // Set MIE
    emit(csr_instr(12'h7c0, 11, 1, 13));
    ecall_pc = here_addr();
    emit(32'h0000_0073);
    emit(i_type('h77, 0, 0, 10, 'h13));
    emit(csr_instr(`RV_CSR_MSTATUS, 0, 2, 12));
    emit(s_type('h10, 10, 5, 2));
    emit(s_type('h14, 12, 5, 2));
    emit(s_type('h18, 13, 5, 2));
    emit(EBREAK);
    pc_idx = 64; // Trap handler
    for (int i = 0; i < 4; i++) begin
      emit(csr_instr(i == 0 ? `RV_CSR_MCAUSE : i == 1 ? `RV_CSR_MEPC :
          i == 2 ? `RV_CSR_MSTATUS : `RV_CSR_MTVEC, 0, 2, 5'(6 + i)));
      emit(s_type(4 * i, 5'(6 + i), 5, 2));
    end
    emit(i_type(4, 7, 0, 7, 'h13));
    emit(csr_instr(`RV_CSR_MEPC, 7, 1, 0));
    emit(32'h3020_0073);
    ms_trap = 32'h0000_0080 | 32'h0000_1800; // MPIE set and MPP 3 in the handler
    ms_ret  = ms_trap | 32'h0000_0008;
    run_program("CSR/trap");
    expect_word(mem_word('h0), `RV_CAUSE_ECALL, "mcause");
    expect_word(mem_word('h4), ecall_pc, "mepc");
    expect_word(mem_word('h8), ms_trap, "mstatus in handler");
    expect_word(mem_word('hc), handler, "mtvec");
    expect_word(mem_word('h10), 32'h77, "marker after ecall");
    expect_word(mem_word('h14), ms_ret, "mstatus after mret");
    expect_word(mem_word('h18), 32'd0, "unknown CSR read");
  endtask

  task automatic test_halt();
    logic [31:0] a, b, halt_pc;
    start_program();
    a = next_rand();
    b = next_rand();
    load_const(10, a);
    load_const(11, b);
    emit(r_type(0, 11, 10, 0, 10));
    halt_pc = here_addr();
    emit(EBREAK);
    emit(s_type(0, 10, 5, 2));
    run_program("halt");
    expect_word(a0, a + b, "a0");
    repeat (20) begin
      @(negedge clk);
      expect_true(halt && !dmem_we, "halt dropped or a store appeared while halted");
      expect_word(imem_addr, halt_pc, "fetch address while halted");
    end
  endtask

  initial begin
    rst = 1'b1;
    test_alu();
    test_load_store();
    test_control_flow();
    test_csr_trap();
    test_halt();
    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
